/* Makefile */
# Verilator simulation of the pipeline testbench
SIM_LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f verilog.f --top-module tb_top -Mdir obj_dir -o tb_top

run: build
	obj_dir/tb_top | tee $(SIM_LOG)
	grep -q "All checks passed" $(SIM_LOG)

lint:
	verilator --lint-only --timing -f verilog.f --top-module tb_top

clean:
	rm -rf obj_dir $(SIM_LOG)

/* common/mips_pkg.sv */
package mips_pkg;

    parameter int data_width     = 32;
    parameter int reg_addr_width = 5;

    typedef logic [data_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f
    } opcode_e;

    // function field for op_special, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_j
    } branch_e;

endpackage

/* decode/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                aclk,
    input  logic                reset,
    input  logic                redirect,
    input  mips_pkg::word_t     if_pc,
    input  mips_pkg::word_t     if_instr,
    input  logic                wb_wen,
    input  mips_pkg::reg_addr_t wb_dst,
    input  mips_pkg::word_t     wb_result,
    output mips_pkg::word_t     id_pc,
    output mips_pkg::word_t     id_rs_val,
    output mips_pkg::word_t     id_rt_val,
    output mips_pkg::reg_addr_t id_rs,
    output mips_pkg::reg_addr_t id_rt,
    output mips_pkg::word_t     id_imm,
    output logic                id_use_imm,
    output mips_pkg::alu_op_e   id_alu_op,
    output mips_pkg::branch_e   id_branch,
    output logic [25:0]         id_jump_index,
    output mips_pkg::reg_addr_t id_dst,
    output logic                id_wen
);
    import mips_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;
    logic      use_imm;
    alu_op_e   alu_op;
    branch_e   branch;
    reg_addr_t dst;
    logic      valid;                          // encoding is one we execute
    logic      wen;

    assign opcode = opcode_e'(if_instr[31:26]);
    assign funct  = funct_e'(if_instr[5:0]);
    assign rs     = if_instr[25:21];
    assign rt     = if_instr[20:16];

    reg_file i_reg_file (
        .aclk   (aclk),
        .reset  (reset),
        .rs     (rs),
        .rt     (rt),
        .wen    (wb_wen),
        .wdst   (wb_dst),
        .wdata  (wb_result),
        .rs_val (rs_val),
        .rt_val (rt_val)
    );

    always_comb begin
        alu_op  = alu_add;
        use_imm = 1'b0;
        imm     = {{16{if_instr[15]}}, if_instr[15:0]};   // sign extended by default
        branch  = br_none;
        dst     = if_instr[15:11];             // rd for R-type
        valid   = 1'b1;
        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    default: valid = 1'b0;
                endcase
            end
            op_addiu: begin
                use_imm = 1'b1;
                dst     = rt;
            end
            op_ori: begin
                alu_op  = alu_or;
                use_imm = 1'b1;
                imm     = {16'h0, if_instr[15:0]};
                dst     = rt;
            end
            op_lui: begin
                alu_op  = alu_lui;
                use_imm = 1'b1;
                imm     = {16'h0, if_instr[15:0]};
                dst     = rt;
            end
            op_beq:  branch = br_beq;
            op_bne:  branch = br_bne;
            op_j:    branch = br_j;
            default: valid = 1'b0;             // unsupported encoding runs as a bubble
        endcase
    end

    assign wen = valid && (branch == br_none) && (dst != '0);

    // decode/execute register
    always_ff @(posedge aclk) begin
        if (reset || redirect) begin
            id_pc         <= '0;
            id_rs_val     <= '0;
            id_rt_val     <= '0;
            id_rs         <= '0;
            id_rt         <= '0;
            id_imm        <= '0;
            id_use_imm    <= 1'b0;
            id_alu_op     <= alu_add;
            id_branch     <= br_none;
            id_jump_index <= '0;
            id_dst        <= '0;
            id_wen        <= 1'b0;
        end else begin
            id_pc         <= if_pc;
            id_rs_val     <= rs_val;
            id_rt_val     <= rt_val;
            id_rs         <= rs;
            id_rt         <= rt;
            id_imm        <= imm;
            id_use_imm    <= use_imm;
            id_alu_op     <= alu_op;
            id_branch     <= branch;
            id_jump_index <= if_instr[25:0];
            id_dst        <= dst;
            id_wen        <= wen;
        end
    end

endmodule

/* decode/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic              aclk,
    input  logic              reset,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic              wen,
    input  mips_pkg::reg_addr_t wdst,
    input  mips_pkg::word_t   wdata,
    output mips_pkg::word_t   rs_val,
    output mips_pkg::word_t   rt_val
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge aclk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wen && wdst != '0) begin
            regs[wdst] <= wdata;
        end
    end

    // r0 is hardwired, a same-cycle write is passed straight through
    assign rs_val = (rs == '0) ? '0 : (wen && wdst == rs) ? wdata : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (wen && wdst == rt) ? wdata : regs[rt];

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  mips_pkg::word_t     id_pc,
    input  mips_pkg::word_t     id_rs_val,
    input  mips_pkg::word_t     id_rt_val,
    input  mips_pkg::reg_addr_t id_rs,
    input  mips_pkg::reg_addr_t id_rt,
    input  mips_pkg::word_t     id_imm,
    input  logic                id_use_imm,
    input  mips_pkg::alu_op_e   id_alu_op,
    input  mips_pkg::branch_e   id_branch,
    input  logic [25:0]         id_jump_index,
    input  mips_pkg::reg_addr_t id_dst,
    input  logic                id_wen,
    input  logic                wb_wen,
    input  mips_pkg::reg_addr_t wb_dst,
    input  mips_pkg::word_t     wb_result,
    output mips_pkg::word_t     ex_pc,
    output mips_pkg::word_t     ex_result,
    output mips_pkg::reg_addr_t ex_dst,
    output logic                ex_wen,
    output logic                redirect,
    output mips_pkg::word_t     redirect_pc
);
    import mips_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t alu_b;
    word_t pc_plus4;
    word_t branch_target;
    word_t jump_target;
    logic  equal;

    // bypass from the retiring instruction, distance 1
    assign src_a = (wb_wen && wb_dst == id_rs) ? wb_result : id_rs_val;
    assign src_b = (wb_wen && wb_dst == id_rt) ? wb_result : id_rt_val;
    assign alu_b = id_use_imm ? id_imm : src_b;

    always_comb begin
        case (id_alu_op)
            alu_add: ex_result = src_a + alu_b;
            alu_sub: ex_result = src_a - alu_b;
            alu_and: ex_result = src_a & alu_b;
            alu_or:  ex_result = src_a | alu_b;
            alu_xor: ex_result = src_a ^ alu_b;
            alu_slt: ex_result = word_t'($signed(src_a) < $signed(alu_b));
            alu_lui: ex_result = {alu_b[15:0], 16'h0};
            default: ex_result = '0;
        endcase
    end

    assign pc_plus4      = id_pc + 32'd4;
    assign branch_target = pc_plus4 + {id_imm[data_width-3:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], id_jump_index, 2'b00};
    assign equal         = (src_a == src_b);

    // only place the branch condition is tested
    always_comb begin
        case (id_branch)
            br_beq:  redirect = equal;
            br_bne:  redirect = !equal;
            br_j:    redirect = 1'b1;
            default: redirect = 1'b0;
        endcase
    end

    assign redirect_pc = (id_branch == br_j) ? jump_target : branch_target;

    assign ex_pc  = id_pc;
    assign ex_dst = id_dst;
    assign ex_wen = id_wen;                    // branches already carry wen low

endmodule

/* fetch/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage #(
    parameter mips_pkg::word_t reset_vector = 32'hbfc0_0000
) (
    input  logic            aclk,
    input  logic            reset,
    input  logic            redirect,      // taken branch or jump in execute
    input  mips_pkg::word_t redirect_pc,
    input  mips_pkg::word_t imem_rdata,    // same-cycle instruction read
    output mips_pkg::word_t imem_addr,
    output mips_pkg::word_t if_pc,
    output mips_pkg::word_t if_instr
);
    import mips_pkg::*;

    word_t pc;

    assign imem_addr = pc;

    always_ff @(posedge aclk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // fetch/decode register
    // the word fetched alongside a redirect is squashed
    always_ff @(posedge aclk) begin
        if (reset || redirect) begin
            if_pc    <= '0;
            if_instr <= '0;                    // all-zero word decodes as a bubble
        end else begin
            if_pc    <= pc;
            if_instr <= imem_rdata;
        end
    end

endmodule

/* verification/tb_top.sv */
`timescale 1ns/1ns

module tb_top;
    import mips_pkg::*;

    localparam word_t reset_vector = 32'hbfc0_0000;

    logic        aclk;
    logic        reset;
    word_t       imem_rdata;
    word_t       imem_addr;
    word_t       debug_wb_pc;
    word_t       debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    reg_addr_t   debug_wb_rf_wnum;

    word_t       imem [0:63];
    word_t       word_index;
    word_t       prog [$];                     // program under test
    word_t       exp_pc [$];
    word_t       exp_num [$];
    word_t       exp_val [$];
    integer      seed;
    longint      deadline;                     // grows with every program

    mycpu_top i_dut (
        .aclk              (aclk),
        .reset             (reset),
        .imem_rdata        (imem_rdata),
        .imem_addr         (imem_addr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    always #50 aclk = ~aclk;

    // same-cycle instruction memory that reads zero outside the program window
    assign word_index = (imem_addr - reset_vector) >> 2;
    assign imem_rdata = (word_index < 32'd64) ? imem[word_index[5:0]] : 32'h0;

    function automatic word_t rtype_word(input logic [5:0] fn, input int rd, input int rs,
                                         input int rt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'h00, fn};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input int rt, input int rs,
                                         input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic word_t jump_word(input int word);
        word_t target;
        target = reset_vector + 32'(word * 4);
        return {op_j, target[27:2]};
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Checks failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // reference model stepping one instruction at a time without a delay slot
    task automatic build_expected;
        word_t regs_m [32];
        word_t pc;
        word_t next;
        word_t w;
        word_t a;
        word_t b;
        word_t sext;
        word_t val;
        reg_addr_t dst;
        logic  wr;
        int    idx;
        int    steps;
        foreach (regs_m[k]) regs_m[k] = 32'h0;
        exp_pc.delete();
        exp_num.delete();
        exp_val.delete();
        pc = reset_vector;
        idx = 0;
        steps = 0;
        while (idx < prog.size() && steps < 200) begin
            w = prog[idx];
            a = regs_m[w[25:21]];
            b = regs_m[w[20:16]];
            sext = {{16{w[15]}}, w[15:0]};
            val = 32'h0;
            dst = w[20:16];                    // rt for immediate forms
            wr = 1'b1;
            next = pc + 32'd4;
            case (w[31:26])
                op_special: begin
                    dst = w[15:11];
                    case (w[5:0])
                        fn_addu: val = a + b;
                        fn_subu: val = a - b;
                        fn_and:  val = a & b;
                        fn_or:   val = a | b;
                        fn_xor:  val = a ^ b;
                        fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                op_addiu: val = a + sext;
                op_ori:   val = a | {16'h0, w[15:0]};
                op_lui:   val = {w[15:0], 16'h0};
                op_beq: begin
                    wr = 1'b0;
                    if (a == b) next = pc + 32'd4 + {sext[29:0], 2'b00};
                end
                op_bne: begin
                    wr = 1'b0;
                    if (a != b) next = pc + 32'd4 + {sext[29:0], 2'b00};
                end
                op_j: begin
                    wr = 1'b0;
                    next = {next[31:28], w[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs_m[dst] = val;
                exp_pc.push_back(pc);
                exp_num.push_back({27'h0, dst});
                exp_val.push_back(val);
            end
            pc = next;
            idx = int'((pc - reset_vector) >> 2);
            steps++;
        end
    endtask

    task automatic pulse_reset;
        @(negedge aclk);
        reset = 1'b1;
        repeat (3) begin
            @(negedge aclk);
            check_value({28'h0, debug_wb_rf_wen}, 32'h0, "write enable during reset");
            check_value(imem_addr, reset_vector, "fetch address during reset");
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge aclk);
            check_value({28'h0, debug_wb_rf_wen}, 32'h0, "write enable after reset");
        end
    endtask

    task automatic run_program(input string name);
        int i;
        int cycles;
        deadline = deadline + longint'((prog.size() + 10) * 100);
        foreach (imem[k]) imem[k] = 32'h0;
        for (i = 0; i < prog.size(); i++) imem[i[5:0]] = prog[i];
        build_expected();
        pulse_reset();
        cycles = prog.size() + 2;
        for (i = 0; i < cycles; i++) begin
            @(negedge aclk);
            if (i == 0 && exp_pc.size() > 0 && exp_pc[0] == reset_vector) begin
                check_value({28'h0, debug_wb_rf_wen}, 32'hf, "first write 3 cycles after reset");
            end
            if (debug_wb_rf_wen != 4'h0) begin
                if (exp_pc.size() == 0) begin
                    $display("%s: unexpected register write from pc %h at %0t ns", name,
                             debug_wb_pc, $time);
                    $display("Checks failed");
                    $fatal(1, "extra register write");
                end else begin
                    check_value({28'h0, debug_wb_rf_wen}, 32'hf, "write enable bits");
                    check_value(debug_wb_pc, exp_pc.pop_front(), "trace pc");
                    check_value({27'h0, debug_wb_rf_wnum}, exp_num.pop_front(), "trace rd");
                    check_value(debug_wb_rf_wdata, exp_val.pop_front(), "trace data");
                end
            end
        end
        if (exp_pc.size() != 0) begin
            $display("%s: %0d expected register writes never showed up", name, exp_pc.size());
            $display("Checks failed");
            $fatal(1, "missing register writes");
        end
        prog.delete();
    endtask

    task automatic alu_ops_test;
        prog.push_back(itype_word(op_addiu, 1, 0, 16'h1234));
        prog.push_back(itype_word(op_addiu, 2, 0, 16'hfffb));   // -5
        prog.push_back(itype_word(op_lui, 3, 0, 16'h8000));
        prog.push_back(itype_word(op_ori, 4, 0, 16'hf0f0));
        prog.push_back(rtype_word(fn_addu, 5, 1, 2));
        prog.push_back(rtype_word(fn_subu, 6, 1, 2));
        prog.push_back(rtype_word(fn_and, 7, 1, 4));
        prog.push_back(rtype_word(fn_or, 8, 1, 4));
        prog.push_back(rtype_word(fn_xor, 9, 1, 4));
        prog.push_back(rtype_word(fn_slt, 10, 2, 1));           // negative < positive
        prog.push_back(rtype_word(fn_slt, 11, 1, 2));
        prog.push_back(rtype_word(fn_slt, 12, 3, 2));
        prog.push_back(itype_word(op_ori, 13, 2, 16'h00ff));
        prog.push_back(itype_word(op_lui, 14, 0, 16'h5a5a));
        run_program("alu ops");
    endtask

    task automatic dependence_test;
        prog.push_back(itype_word(op_addiu, 1, 0, 16'h0005));
        prog.push_back(rtype_word(fn_addu, 2, 1, 1));           // distance 1
        prog.push_back(itype_word(op_addiu, 3, 0, 16'h0007));
        prog.push_back(32'h0);
        prog.push_back(rtype_word(fn_subu, 4, 3, 1));           // distance 2
        prog.push_back(itype_word(op_lui, 5, 0, 16'h0009));
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(rtype_word(fn_xor, 6, 5, 3));            // distance 3
        prog.push_back(itype_word(op_addiu, 7, 7, 16'h0001));
        prog.push_back(itype_word(op_addiu, 7, 7, 16'h0001));
        prog.push_back(rtype_word(fn_addu, 7, 7, 2));
        run_program("dependence");
    endtask

    task automatic branch_test;
        prog.push_back(itype_word(op_addiu, 1, 0, 16'h0004));
        prog.push_back(itype_word(op_addiu, 2, 0, 16'h0004));
        prog.push_back(itype_word(op_beq, 2, 1, 16'h0002));     // taken to word 5
        prog.push_back(itype_word(op_addiu, 3, 0, 16'h0001));
        prog.push_back(itype_word(op_addiu, 3, 0, 16'h0002));
        prog.push_back(itype_word(op_bne, 2, 1, 16'h0001));     // not taken
        prog.push_back(itype_word(op_addiu, 4, 0, 16'h0011));
        prog.push_back(itype_word(op_beq, 0, 1, 16'h0001));     // not taken
        prog.push_back(itype_word(op_addiu, 5, 0, 16'h0022));
        prog.push_back(itype_word(op_bne, 0, 1, 16'h0002));     // taken to word 12
        prog.push_back(itype_word(op_addiu, 6, 0, 16'h0001));
        prog.push_back(itype_word(op_addiu, 6, 0, 16'h0002));
        prog.push_back(jump_word(15));
        prog.push_back(itype_word(op_addiu, 7, 0, 16'h0001));
        prog.push_back(itype_word(op_addiu, 7, 0, 16'h0002));
        prog.push_back(itype_word(op_addiu, 8, 0, 16'h0033));
        run_program("branches");
    endtask

    task automatic zero_reg_test;
        prog.push_back(itype_word(op_addiu, 1, 0, 16'h0077));
        prog.push_back(itype_word(op_addiu, 0, 0, 16'h0005));
        prog.push_back(itype_word(op_addiu, 3, 0, 16'h0000));   // right behind an r0 write
        prog.push_back(itype_word(op_lui, 0, 0, 16'hffff));
        prog.push_back(itype_word(op_ori, 0, 1, 16'h0001));
        prog.push_back(rtype_word(fn_addu, 0, 1, 1));
        prog.push_back(rtype_word(fn_addu, 1, 0, 0));
        prog.push_back(rtype_word(fn_or, 2, 0, 1));
        run_program("register zero");
    endtask

    task automatic random_chain_test;
        word_t r;
        repeat (20) begin
            r = $random(seed);
            case (r[31:30])
                2'd0:    prog.push_back(itype_word(op_addiu, int'(r[4:0]), int'(r[9:5]), r[25:10]));
                2'd1:    prog.push_back(itype_word(op_ori, int'(r[4:0]), int'(r[9:5]), r[25:10]));
                default: prog.push_back(itype_word(op_lui, int'(r[4:0]), int'(r[9:5]), r[25:10]));
            endcase
        end
        run_program("random chain");
    endtask

    initial begin : watchdog
        forever begin
            #100;
            if ($time > deadline) begin
                $display("timeout: the run went past %0d ns without finishing", deadline);
                $display("Checks failed");
                $fatal(1, "watchdog expired");
            end
        end
    end

    initial begin
        aclk = 1'b0;
        reset = 1'b1;
        seed = 71;
        deadline = 0;
        alu_ops_test();
        dependence_test();
        branch_test();
        zero_reg_test();
        random_chain_test();
        $display("All checks passed");
        $finish;
    end

endmodule

/* verilog.f */
common/mips_pkg.sv
fetch/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
verilog/writeback_stage.sv
verilog/mycpu_top.sv
verification/tb_top.sv

/* verilog/mycpu_top.sv */
`timescale 1ns/1ns

module mycpu_top #(
    parameter mips_pkg::word_t reset_vector = 32'hbfc0_0000
) (
    input  logic                aclk,
    input  logic                reset,
    input  mips_pkg::word_t     imem_rdata,
    output mips_pkg::word_t     imem_addr,
    output mips_pkg::word_t     debug_wb_pc,
    output mips_pkg::word_t     debug_wb_rf_wdata,
    output logic [3:0]          debug_wb_rf_wen,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum
);
    import mips_pkg::*;

    word_t       if_pc;
    word_t       if_instr;
    word_t       id_pc;
    word_t       id_rs_val;
    word_t       id_rt_val;
    reg_addr_t   id_rs;
    reg_addr_t   id_rt;
    word_t       id_imm;
    logic        id_use_imm;
    alu_op_e     id_alu_op;
    branch_e     id_branch;
    logic [25:0] id_jump_index;
    reg_addr_t   id_dst;
    logic        id_wen;
    word_t       ex_pc;
    word_t       ex_result;
    reg_addr_t   ex_dst;
    logic        ex_wen;
    logic        redirect;                     // flushes fetch and decode
    word_t       redirect_pc;
    word_t       wb_pc;
    word_t       wb_result;
    reg_addr_t   wb_dst;
    logic        wb_wen;

    fetch_stage #(
        .reset_vector (reset_vector)
    ) i_fetch_stage (
        .aclk        (aclk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_rdata  (imem_rdata),
        .imem_addr   (imem_addr),
        .if_pc       (if_pc),
        .if_instr    (if_instr)
    );

    decode_stage i_decode_stage (
        .aclk          (aclk),
        .reset         (reset),
        .redirect      (redirect),
        .if_pc         (if_pc),
        .if_instr      (if_instr),
        .wb_wen        (wb_wen),
        .wb_dst        (wb_dst),
        .wb_result     (wb_result),
        .id_pc         (id_pc),
        .id_rs_val     (id_rs_val),
        .id_rt_val     (id_rt_val),
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_imm        (id_imm),
        .id_use_imm    (id_use_imm),
        .id_alu_op     (id_alu_op),
        .id_branch     (id_branch),
        .id_jump_index (id_jump_index),
        .id_dst        (id_dst),
        .id_wen        (id_wen)
    );

    execute_stage i_execute_stage (
        .id_pc         (id_pc),
        .id_rs_val     (id_rs_val),
        .id_rt_val     (id_rt_val),
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_imm        (id_imm),
        .id_use_imm    (id_use_imm),
        .id_alu_op     (id_alu_op),
        .id_branch     (id_branch),
        .id_jump_index (id_jump_index),
        .id_dst        (id_dst),
        .id_wen        (id_wen),
        .wb_wen        (wb_wen),
        .wb_dst        (wb_dst),
        .wb_result     (wb_result),
        .ex_pc         (ex_pc),
        .ex_result     (ex_result),
        .ex_dst        (ex_dst),
        .ex_wen        (ex_wen),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

    writeback_stage i_writeback_stage (
        .aclk      (aclk),
        .reset     (reset),
        .ex_pc     (ex_pc),
        .ex_result (ex_result),
        .ex_dst    (ex_dst),
        .ex_wen    (ex_wen),
        .wb_pc     (wb_pc),
        .wb_result (wb_result),
        .wb_dst    (wb_dst),
        .wb_wen    (wb_wen)
    );

    // golden trace
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wdata = wb_result;
    assign debug_wb_rf_wen   = {4{wb_wen}};   // byte enables, all or nothing
    assign debug_wb_rf_wnum  = wb_dst;

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/1ns

module writeback_stage (
    input  logic                aclk,
    input  logic                reset,
    input  mips_pkg::word_t     ex_pc,
    input  mips_pkg::word_t     ex_result,
    input  mips_pkg::reg_addr_t ex_dst,
    input  logic                ex_wen,
    output mips_pkg::word_t     wb_pc,
    output mips_pkg::word_t     wb_result,
    output mips_pkg::reg_addr_t wb_dst,
    output logic                wb_wen
);

    // execute/writeback register, feeds the rf write port and the trace
    always_ff @(posedge aclk) begin
        if (reset) begin
            wb_pc     <= '0;
            wb_result <= '0;
            wb_dst    <= '0;
            wb_wen    <= 1'b0;
        end else begin
            wb_pc     <= ex_pc;
            wb_result <= ex_result;
            wb_dst    <= ex_dst;
            wb_wen    <= ex_wen;
        end
    end

endmodule
